// File: Makefile
VERILATOR ?= verilator
VFLAGS = --timing
TOP = control_unit_tb
FILELIST = sim.f
OBJ_DIR = obj_dir
PASS_MSG = TESTS PASSED

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only if the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/branch_condition.sv
`timescale 1ns/10ps

module branch_condition (
	input logic [legv8_pkg::INSTR_W-1:0] instr,
	input logic [legv8_pkg::STATUS_W-1:0] status,
	output logic take_branch
);

	import legv8_pkg::*;

	logic v;
	logic c;
	logic n;
	logic z;
	logic cond_met;
	logic is_cb;

	assign v = status[STAT_V];
	assign c = status[STAT_C];
	assign n = status[STAT_N];
	assign z = status[STAT_Z];

	// b.cond condition code in I[3:0]
	always_comb begin
		case (instr[3:0])
			4'h0: cond_met = z;
			4'h1: cond_met = ~z;
			4'h2: cond_met = c;
			4'h3: cond_met = ~c;
			4'h4: cond_met = n;
			4'h5: cond_met = ~n;
			4'h6: cond_met = v;
			4'h7: cond_met = ~v;
			// unsigned higher / lower or same
			4'h8: cond_met = c & ~z;
			4'h9: cond_met = ~c | z;
			// signed compares
			4'ha: cond_met = ~(n ^ v);
			4'hb: cond_met = n ^ v;
			4'hc: cond_met = ~z & ~(n ^ v);
			4'hd: cond_met = z | (n ^ v);
			4'he: cond_met = 1'b1;
			default: cond_met = 1'b0;
		endcase
	end

	// cbz when I24 is 0, cbnz when 1
	assign is_cb = (instr[31:25] == 7'b1011010);
	assign take_branch = is_cb ? (status[STAT_ZRAW] ^ instr[24]) : cond_met;

endmodule

// File: logic/constant_generator.sv
`timescale 1ns/10ps

module constant_generator (
	input logic [legv8_pkg::INSTR_W-1:0] instr,
	input legv8_pkg::const_sel_e const_sel,
	output logic [legv8_pkg::CONST_W-1:0] constant
);

	import legv8_pkg::*;

	always_comb begin
		case (const_sel)
			// alu immediates
			CS_ZF_12: begin
				constant = {{(CONST_W - 12){1'b0}}, instr[21:10]};
			end
			// movz / movk halfword
			CS_ZF_16: begin
				constant = {{(CONST_W - 16){1'b0}}, instr[20:5]};
			end
			// clears the low halfword before the movk merge
			CS_MOVK_MASK: begin
				constant = {{(CONST_W - 16){1'b1}}, 16'h0000};
			end
			// b / bl offset
			CS_SE_26: begin
				constant = {{(CONST_W - 26){instr[25]}}, instr[25:0]};
			end
			// cbz and b.cond offset
			CS_SE_19: begin
				constant = {{(CONST_W - 19){instr[23]}}, instr[23:5]};
			end
			// ldur/stur address offset
			CS_SE_9: begin
				constant = {{(CONST_W - 9){instr[20]}}, instr[20:12]};
			end
			CS_LOW_MASK: begin
				constant = {{(CONST_W - 32){1'b0}}, 32'hffff_ffff};
			end
			default: begin
				constant = '0;
			end
		endcase
	end

endmodule

// File: logic/control_sequencer.sv
`timescale 1ns/10ps

module control_sequencer (
	input logic clock,
	input logic rst,
	input logic [legv8_pkg::INSTR_W-1:0] instr,
	input legv8_pkg::instr_class_e instr_class,
	input logic take_branch,
	output legv8_pkg::cu_state_e state,
	output legv8_pkg::const_sel_e const_sel,
	output logic as,
	output logic [1:0] ds,
	output logic [1:0] ps,
	output logic pc_sel,
	output logic b_sel,
	output logic il,
	output logic sl,
	output legv8_pkg::alu_fs_e fs,
	output logic c0,
	output logic [1:0] size,
	output logic mw,
	output logic rw,
	output logic [legv8_pkg::REG_W-1:0] da,
	output logic [legv8_pkg::REG_W-1:0] sa,
	output logic [legv8_pkg::REG_W-1:0] sb
);

	import legv8_pkg::*;

	cu_state_e next_state;
	alu_fs_e arith_fs;
	alu_fs_e logic_fs;
	logic ands_flags;
	logic [1:0] cond_ps;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= ST_IF;
		end else begin
			state <= next_state;
		end
	end

	// movk (I29 set) and mul take a second execute step
	always_comb begin
		case (state)
			ST_IF: next_state = ST_EX0;
			ST_EX0: begin
				if ((instr_class == CL_MOV && instr[29]) || instr_class == CL_MUL) begin
					next_state = ST_EX1;
				end else begin
					next_state = ST_IF;
				end
			end
			default: next_state = ST_IF;
		endcase
	end

	// add/sub from I30, I29 sets flags
	assign arith_fs = instr[30] ? FS_SUB : FS_ADD;

	// and, orr, eor, ands from I[30:29]
	always_comb begin
		case (instr[30:29])
			2'b01: logic_fs = FS_OR;
			2'b10: logic_fs = FS_XOR;
			default: logic_fs = FS_AND;
		endcase
	end
	assign ands_flags = instr[30] & instr[29];

	// conditional branch: pc + offset when taken, hold otherwise
	assign cond_ps = take_branch ? 2'b11 : 2'b00;

	always_comb begin
		// idle word, register fields straight from the instruction
		as = 1'b0;
		ds = 2'b00;
		ps = 2'b00;
		pc_sel = 1'b0;
		b_sel = 1'b0;
		il = 1'b0;
		sl = 1'b0;
		fs = FS_ZERO;
		c0 = 1'b0;
		size = 2'b11;
		mw = 1'b0;
		rw = 1'b0;
		da = instr[4:0];
		sa = instr[9:5];
		sb = instr[20:16];
		const_sel = CS_ZERO;
		case (state)
			// fetch from pc, load ir, pc + 4
			ST_IF: begin
				as = 1'b1;
				ds = 2'b11;
				ps = 2'b01;
				il = 1'b1;
			end
			ST_EX0: begin
				case (instr_class)
					CL_ARITH_IMM, CL_ARITH_REG: begin
						b_sel = (instr_class == CL_ARITH_IMM);
						sl = instr[29];
						fs = arith_fs;
						c0 = instr[30];
						rw = 1'b1;
						const_sel = CS_ZF_12;
					end
					CL_LOGIC_IMM, CL_LOGIC_REG: begin
						b_sel = (instr_class == CL_LOGIC_IMM);
						sl = ands_flags;
						fs = logic_fs;
						rw = 1'b1;
						const_sel = CS_ZF_12;
					end
					CL_MOV: begin
						b_sel = 1'b1;
						rw = 1'b1;
						if (instr[29]) begin
							// movk step 1: rd & mask clears low halfword
							sa = instr[4:0];
							fs = FS_AND;
							const_sel = CS_MOVK_MASK;
						end else begin
							// movz writes the halfword alone
							fs = FS_PASS_B;
							const_sel = CS_ZF_16;
						end
					end
					CL_B_BL: begin
						// bl links pc + 4 into x30
						ds = 2'b10;
						ps = 2'b11;
						pc_sel = 1'b1;
						rw = instr[31];
						da = 5'd30;
						const_sel = CS_SE_26;
					end
					CL_CBZ: begin
						// xzr + rt so the ALU raw zero flag reflects rt
						ps = cond_ps;
						pc_sel = 1'b1;
						fs = FS_ADD;
						sa = 5'd31;
						sb = instr[4:0];
						const_sel = CS_SE_19;
					end
					CL_BCOND: begin
						ps = cond_ps;
						pc_sel = 1'b1;
						const_sel = CS_SE_19;
					end
					CL_BR: begin
						// pc from register rn
						ps = 2'b10;
					end
					CL_LDUR_STUR: begin
						// I22 set for load
						ds = {instr[22], 1'b1};
						b_sel = 1'b1;
						fs = FS_ADD;
						size = instr[31:30];
						mw = ~instr[22];
						rw = instr[22];
						sb = instr[4:0];
						const_sel = CS_SE_9;
					end
					CL_MUL: begin
						// step 1 stages low word of rn in rd
						b_sel = 1'b1;
						fs = FS_AND;
						rw = 1'b1;
						const_sel = CS_LOW_MASK;
					end
					default: begin
						// unsupported, no writes, on to next pc
						ps = 2'b01;
					end
				endcase
			end
			ST_EX1: begin
				rw = 1'b1;
				sa = instr[4:0];
				if (instr_class == CL_MOV) begin
					// movk merge of the halfword into rd
					b_sel = 1'b1;
					fs = FS_OR;
					const_sel = CS_ZF_16;
				end else begin
					// mul step 2 combines staged rd with rm
					fs = FS_ADD;
				end
			end
			default: begin
				ps = 2'b01;
			end
		endcase
	end

endmodule

// File: logic/control_unit.sv
`timescale 1ns/10ps

module control_unit (
	input logic clock,
	input logic rst,
	input logic [legv8_pkg::INSTR_W-1:0] instr,
	input logic [legv8_pkg::STATUS_W-1:0] status,
	output legv8_pkg::cu_state_e state,
	output logic as,
	output logic [1:0] ds,
	output logic [1:0] ps,
	output logic pc_sel,
	output logic b_sel,
	output logic il,
	output logic sl,
	output legv8_pkg::alu_fs_e fs,
	output logic c0,
	output logic [1:0] size,
	output logic mw,
	output logic rw,
	output logic [legv8_pkg::REG_W-1:0] da,
	output logic [legv8_pkg::REG_W-1:0] sa,
	output logic [legv8_pkg::REG_W-1:0] sb,
	output logic [legv8_pkg::CONST_W-1:0] constant
);

	import legv8_pkg::*;

	instr_class_e instr_class;
	const_sel_e const_sel;
	logic take_branch;

	// classifier and condition check run side by side
	instr_classifier u_classifier (
		.instr(instr),
		.instr_class(instr_class)
	);

	branch_condition u_branch_condition (
		.instr(instr),
		.status(status),
		.take_branch(take_branch)
	);

	// state register and control word
	control_sequencer u_sequencer (
		.clock(clock),
		.rst(rst),
		.instr(instr),
		.instr_class(instr_class),
		.take_branch(take_branch),
		.state(state),
		.const_sel(const_sel),
		.as(as),
		.ds(ds),
		.ps(ps),
		.pc_sel(pc_sel),
		.b_sel(b_sel),
		.il(il),
		.sl(sl),
		.fs(fs),
		.c0(c0),
		.size(size),
		.mw(mw),
		.rw(rw),
		.da(da),
		.sa(sa),
		.sb(sb)
	);

	// immediate under the sequencer's select
	constant_generator u_constant_generator (
		.instr(instr),
		.const_sel(const_sel),
		.constant(constant)
	);

endmodule

// File: logic/instr_classifier.sv
`timescale 1ns/10ps

module instr_classifier (
	input logic [legv8_pkg::INSTR_W-1:0] instr,
	output legv8_pkg::instr_class_e instr_class
);

	import legv8_pkg::*;

	// ldur/stur need opc bits 11, unscaled offset form, no register offset
	logic mem_is_ldur_stur;

	assign mem_is_ldur_stur = instr[29] & instr[28] & ~instr[24] & ~instr[21] &
		~instr[11] & ~instr[10];

	always_comb begin
		instr_class = CL_NONE;
		// top level group from I[28:25]
		casez (instr[28:25])
			// data processing, immediate
			4'b100?: begin
				case (instr[25:23])
					3'b010: instr_class = CL_ARITH_IMM;
					3'b100: instr_class = CL_LOGIC_IMM;
					3'b101: instr_class = CL_MOV;
					// bitfield and extr not handled
					default: instr_class = CL_NONE;
				endcase
			end
			// branches, I25 is an offset bit for b/bl
			4'b101?: begin
				casez ({instr[30], instr[29], instr[25]})
					3'b00?: instr_class = CL_B_BL;
					3'b010: instr_class = CL_CBZ;
					3'b100: instr_class = CL_BCOND;
					3'b101: instr_class = CL_BR;
					default: instr_class = CL_NONE;
				endcase
			end
			// loads and stores
			4'b?1?0: begin
				if (mem_is_ldur_stur) begin
					instr_class = CL_LDUR_STUR;
				end else begin
					instr_class = CL_NONE;
				end
			end
			// data processing, register
			4'b?101: begin
				case ({instr[28], instr[24]})
					2'b00: instr_class = CL_LOGIC_REG;
					2'b01: instr_class = CL_ARITH_REG;
					2'b11: instr_class = CL_MUL;
					// misc data-register group not handled
					default: instr_class = CL_NONE;
				endcase
			end
			default: instr_class = CL_NONE;
		endcase
	end

endmodule

// File: logic/legv8_pkg.sv
package legv8_pkg;

	// fixed architecture widths
	localparam int INSTR_W = 32;
	localparam int CONST_W = 64;
	localparam int STATUS_W = 5;
	localparam int REG_W = 5;

	// status bit positions
	localparam int STAT_V = 4;
	localparam int STAT_C = 3;
	localparam int STAT_N = 2;
	localparam int STAT_Z = 1;
	// zero flag straight from the ALU, used by cbz/cbnz
	localparam int STAT_ZRAW = 0;

	// sequencer states
	typedef enum logic [1:0] {
		ST_IF = 2'd0,
		ST_EX0 = 2'd1,
		ST_EX1 = 2'd2
	} cu_state_e;

	// decoded instruction classes
	typedef enum logic [3:0] {
		CL_ARITH_IMM = 4'd0,
		CL_LOGIC_IMM = 4'd1,
		CL_MOV = 4'd2,
		CL_B_BL = 4'd3,
		CL_CBZ = 4'd4,
		CL_BCOND = 4'd5,
		CL_BR = 4'd6,
		CL_LDUR_STUR = 4'd7,
		CL_LOGIC_REG = 4'd8,
		CL_ARITH_REG = 4'd9,
		CL_MUL = 4'd10,
		CL_NONE = 4'd11
	} instr_class_e;

	// immediate forms of the constant generator
	typedef enum logic [2:0] {
		CS_ZF_12 = 3'd0,
		CS_ZF_16 = 3'd1,
		CS_MOVK_MASK = 3'd2,
		CS_SE_26 = 3'd3,
		CS_SE_19 = 3'd4,
		CS_SE_9 = 3'd5,
		CS_LOW_MASK = 3'd6,
		CS_ZERO = 3'd7
	} const_sel_e;

	// ALU function select codes
	typedef enum logic [4:0] {
		FS_AND = 5'b00000,
		FS_OR = 5'b00100,
		FS_XOR = 5'b01100,
		FS_ADD = 5'b01000,
		FS_SUB = 5'b01001,
		FS_PASS_B = 5'b10000,
		FS_ZERO = 5'b11100
	} alu_fs_e;

endpackage

// File: sim.f
+incdir+tb
logic/legv8_pkg.sv
logic/instr_classifier.sv
logic/branch_condition.sv
logic/constant_generator.sv
logic/control_sequencer.sv
logic/control_unit.sv
tb/control_unit_tb.sv

// File: tb/control_model.svh
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// builds an instruction of class cls, free fields taken from r
function automatic logic [31:0] make_instr(instr_class_e cls, logic [31:0] r);
	logic [31:0] i;
	i = r;
	case (cls)
		// addi/subi with optional S, 64-bit, no shift
		CL_ARITH_IMM: begin
			i[31] = 1'b1;
			i[28:22] = 7'b1000100;
		end
		CL_LOGIC_IMM: begin
			i[31] = 1'b1;
			i[28:23] = 6'b100100;
		end
		// I29 picks movz (0) or movk (1), hw = 0
		CL_MOV: begin
			i[31:30] = 2'b11;
			i[28:21] = 8'b10010100;
		end
		// I31 set for bl
		CL_B_BL: i[30:26] = 5'b00101;
		// I24 set for cbnz
		CL_CBZ: i[31:25] = 7'b1011010;
		CL_BCOND: begin
			i[31:24] = 8'b01010100;
			i[4] = 1'b0;
		end
		CL_BR: begin
			i[31:10] = 22'b1101011000011111000000;
			i[4:0] = 5'd0;
		end
		// I22 set for ldur, size in I[31:30]
		CL_LDUR_STUR: begin
			i[29:23] = 7'b1110000;
			i[21] = 1'b0;
			i[11:10] = 2'b00;
		end
		CL_LOGIC_REG: begin
			i[31] = 1'b1;
			i[28:24] = 5'b01010;
			i[21] = 1'b0;
		end
		CL_ARITH_REG: begin
			i[31] = 1'b1;
			i[28:24] = 5'b01011;
			i[21] = 1'b0;
		end
		// ra fixed to xzr
		CL_MUL: begin
			i[31:21] = 11'b10011011000;
			i[15:10] = 6'b011111;
		end
		// bitfield or an unallocated group
		default: begin
			if (r[31]) begin
				i[28:23] = 6'b100110;
			end else begin
				i[28:25] = 4'b0000;
			end
		end
	endcase
	return i;
endfunction

// b.cond or cbz/cbnz outcome from the flags
function automatic logic branch_taken(logic [31:0] i, logic [4:0] st);
	logic v;
	logic c;
	logic n;
	logic z;
	v = st[4];
	c = st[3];
	n = st[2];
	z = st[1];
	// cbz on raw zero, cbnz inverted
	if (i[31:25] == 7'b1011010) begin
		return st[0] ^ i[24];
	end
	case (i[3:0])
		4'd0: return z;
		4'd1: return !z;
		4'd2: return c;
		4'd3: return !c;
		4'd4: return n;
		4'd5: return !n;
		4'd6: return v;
		4'd7: return !v;
		4'd8: return c && !z;
		4'd9: return !(c && !z);
		4'd10: return n == v;
		4'd11: return n != v;
		4'd12: return !z && (n == v);
		4'd13: return z || (n != v);
		4'd14: return 1'b1;
		// nv never taken
		default: return 1'b0;
	endcase
endfunction

// low w bits of v, sign bit copied upward
function automatic logic [63:0] sign_ext(logic [63:0] v, int w);
	logic signed [63:0] t;
	t = v << (64 - w);
	return t >>> (64 - w);
endfunction

function automatic logic two_step(instr_class_e cls, logic [31:0] i);
	return (cls == CL_MUL) || (cls == CL_MOV && i[29]);
endfunction

function automatic alu_fs_e logic_fs_of(logic [31:0] i);
	case (i[30:29])
		2'b01: return FS_OR;
		2'b10: return FS_XOR;
		// and, ands
		default: return FS_AND;
	endcase
endfunction

`endif

// File: tb/control_unit_tb.sv
`timescale 1ns/10ps

module control_unit_tb;

	import legv8_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_INSTR = 300;
	localparam int RESET_CYCLES = 16;
	// three cycles per instruction at worst, plus reset and slack
	localparam int TIMEOUT_NS = (NUM_INSTR * 3 + RESET_CYCLES + 50) * CLK_PERIOD;

	logic clock;
	logic rst;
	logic [31:0] instr;
	logic [4:0] status;
	cu_state_e state;
	logic as;
	logic [1:0] ds;
	logic [1:0] ps;
	logic pc_sel;
	logic b_sel;
	logic il;
	logic sl;
	alu_fs_e fs;
	logic c0;
	logic [1:0] size;
	logic mw;
	logic rw;
	logic [4:0] da;
	logic [4:0] sa;
	logic [4:0] sb;
	logic [63:0] constant;

	integer seed;
	int error_count;
	int check_count;
	instr_class_e cls;
	logic [31:0] cur_instr;
	logic [31:0] rnd;
	logic [4:0] cur_status;
	int unsigned pick;

	`include "control_model.svh"

	control_unit UUT (.*);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task automatic check_state(string name, cu_state_e got, cu_state_e exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Mismatch at %0d ns: %s got %s expected %s", $time, name,
				got.name(), exp.name());
		end
	endtask

	task automatic check_fs(string name, alu_fs_e got, alu_fs_e exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Mismatch at %0d ns: %s got %s expected %s", $time, name,
				got.name(), exp.name());
		end
	endtask

	task automatic check_field(string name, logic [4:0] got, logic [4:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_const(string name, logic [63:0] got, logic [63:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// also holds during reset
	task automatic fetch_word();
		check_state("state", state, ST_IF);
		check_field("il", 5'(il), 5'd1);
		check_field("rw", 5'(rw), 5'd0);
		check_field("mw", 5'(mw), 5'd0);
		check_field("ps", 5'(ps), 5'd1);
		check_field("pc_sel", 5'(pc_sel), 5'd0);
		// address from pc, memory word into ir
		check_field("as", 5'(as), 5'd1);
		check_field("ds", 5'(ds), 5'd3);
	endtask

	// rd written from the ALU, rn on the A side
	task automatic alu_writeback(logic [31:0] i);
		check_field("rw", 5'(rw), 5'd1);
		check_field("mw", 5'(mw), 5'd0);
		check_field("ds", 5'(ds), 5'd0);
		check_field("da", da, i[4:0]);
		check_field("sa", sa, i[9:5]);
	endtask

	task automatic ex0_word(instr_class_e c, logic [31:0] i, logic [4:0] st);
		check_state("state", state, ST_EX0);
		check_field("il", 5'(il), 5'd0);
		check_field("as", 5'(as), 5'd0);
		case (c)
			CL_ARITH_IMM, CL_ARITH_REG: begin
				alu_writeback(i);
				check_fs("fs", fs, i[30] ? FS_SUB : FS_ADD);
				// carry in completes the two's complement for sub
				check_field("c0", 5'(c0), 5'(i[30]));
				check_field("sl", 5'(sl), 5'(i[29]));
				check_field("b_sel", 5'(b_sel), 5'(c == CL_ARITH_IMM));
				if (c == CL_ARITH_IMM) begin
					check_const("constant", constant, {52'd0, i[21:10]});
				end else begin
					check_field("sb", sb, i[20:16]);
				end
			end
			CL_LOGIC_IMM, CL_LOGIC_REG: begin
				alu_writeback(i);
				check_fs("fs", fs, logic_fs_of(i));
				check_field("c0", 5'(c0), 5'd0);
				// only ands sets flags
				check_field("sl", 5'(sl), 5'(i[30:29] == 2'b11));
				check_field("b_sel", 5'(b_sel), 5'(c == CL_LOGIC_IMM));
				if (c == CL_LOGIC_IMM) begin
					check_const("constant", constant, {52'd0, i[21:10]});
				end else begin
					check_field("sb", sb, i[20:16]);
				end
			end
			CL_MOV: begin
				check_field("rw", 5'(rw), 5'd1);
				check_field("ds", 5'(ds), 5'd0);
				check_field("da", da, i[4:0]);
				// movk clears the halfword first
				if (i[29]) begin
					check_const("constant", constant, 64'hffff_ffff_ffff_0000);
				end else begin
					check_const("constant", constant, {48'd0, i[20:5]});
				end
			end
			CL_B_BL: begin
				check_field("pc_sel", 5'(pc_sel), 5'd1);
				check_field("rw", 5'(rw), 5'(i[31]));
				// link value is pc + 4
				check_field("ds", 5'(ds), 5'd2);
				check_field("da", da, 5'd30);
				check_const("constant", constant, sign_ext({38'd0, i[25:0]}, 26));
			end
			CL_CBZ, CL_BCOND: begin
				check_field("ps", 5'(ps), branch_taken(i, st) ? 5'd3 : 5'd0);
				check_field("rw", 5'(rw), 5'd0);
				check_const("constant", constant, sign_ext({45'd0, i[23:5]}, 19));
			end
			CL_BR: begin
				check_field("ps", 5'(ps), 5'd2);
				check_field("sa", sa, i[9:5]);
				check_field("rw", 5'(rw), 5'd0);
			end
			CL_LDUR_STUR: begin
				// I22 set means load
				check_field("mw", 5'(mw), 5'(!i[22]));
				check_field("rw", 5'(rw), 5'(i[22]));
				// load data comes from memory
				if (i[22]) begin
					check_field("ds", 5'(ds), 5'd3);
				end
				check_field("size", 5'(size), 5'(i[31:30]));
				check_field("da", da, i[4:0]);
				check_field("sa", sa, i[9:5]);
				check_field("sb", sb, i[4:0]);
				check_const("constant", constant, sign_ext({55'd0, i[20:12]}, 9));
			end
			CL_MUL: begin
				check_field("rw", 5'(rw), 5'd1);
			end
			default: begin
				check_field("rw", 5'(rw), 5'd0);
				check_field("mw", 5'(mw), 5'd0);
				check_field("ps", 5'(ps), 5'd1);
			end
		endcase
		if (c != CL_LDUR_STUR) begin
			check_field("mw", 5'(mw), 5'd0);
		end
	endtask

	// movk merge or mul second step
	task automatic ex1_word(instr_class_e c, logic [31:0] i);
		check_state("state", state, ST_EX1);
		check_field("il", 5'(il), 5'd0);
		check_field("as", 5'(as), 5'd0);
		check_field("rw", 5'(rw), 5'd1);
		check_field("ds", 5'(ds), 5'd0);
		check_field("mw", 5'(mw), 5'd0);
		check_field("da", da, i[4:0]);
		if (c == CL_MOV) begin
			check_fs("fs", fs, FS_OR);
			check_const("constant", constant, {48'd0, i[20:5]});
		end
	endtask

	initial begin
		seed = 46216;
		error_count = 0;
		check_count = 0;
		rst = 1'b1;
		instr = '0;
		status = '0;
		repeat (RESET_CYCLES - 1) @(posedge clock);
		@(negedge clock);
		fetch_word();
		@(posedge clock);
		rst <= 1'b0;
		for (int n = 0; n < NUM_INSTR; n++) begin
			// new instruction only at the start of fetch
			pick = $unsigned($random(seed)) % 12;
			cls = instr_class_e'(pick[3:0]);
			rnd = $random(seed);
			cur_instr = make_instr(cls, rnd);
			rnd = $random(seed);
			cur_status = rnd[4:0];
			instr <= cur_instr;
			status <= cur_status;
			@(negedge clock);
			fetch_word();
			@(posedge clock);
			@(negedge clock);
			ex0_word(cls, cur_instr, cur_status);
			if (two_step(cls, cur_instr)) begin
				@(posedge clock);
				@(negedge clock);
				ex1_word(cls, cur_instr);
			end
			@(posedge clock);
		end
		// last instruction must hand back to fetch
		@(negedge clock);
		fetch_word();
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before all %0d instructions were run", NUM_INSTR);
		$display("TESTS FAILED");
		$finish;
	end

endmodule
